// ==== hw/spriteAttrPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite attribute types
// One attribute table word and its fields, sprite index and
// raster line widths, plus helpers that unpack a table word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package spriteAttrPkg;

	// Top line, wraps at 512
	typedef logic [8:0] spriteYT;
	// Height in 16-line tiles, bit 5 set covers every line
	typedef logic [5:0] spriteSizeT;
	typedef logic [8:0] spriteIdxT;
	typedef logic [8:0] rasterT;
	// Y in 15:7, chain in 6, size in 5:0
	typedef logic [15:0] attrWordT;

	function automatic spriteYT attrY(attrWordT w);
		return w[15:7];
	endfunction

	function automatic logic attrChain(attrWordT w);
		return w[6];
	endfunction

	function automatic spriteSizeT attrSize(attrWordT w);
		return w[5:0];
	endfunction

endpackage

`default_nettype wire

// ==== hw/parseCtrlPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Parse control types
// Active list addressing, APB address map and the list
// builder state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package parseCtrlPkg;

	typedef logic [6:0] listAddrT;
	typedef logic [7:0] listCountT;
	typedef logic [11:0] apbAddrT;

	typedef enum logic [1:0] {
		idle,
		scanning,
		draining,
		done
	} builderStateT;

	// Byte addresses, one 32-bit slot per word
	localparam apbAddrT tableBase = 12'h000;
	localparam apbAddrT listBase = 12'h800;
	localparam apbAddrT statusAddr = 12'hC00;

endpackage

`default_nettype wire

// ==== hw/attrLaneIf.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Attribute lane
// One fetched table entry and the matcher's verdict on it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface attrLaneIf import spriteAttrPkg::*; ();

	logic valid;
	spriteIdxT index;
	spriteYT y;
	spriteSizeT size;
	logic chain;
	// One cycle behind the fetched fields
	logic hit;
	logic hitValid;

	modport fetch (output valid, index, y, size, chain);
	modport match (input valid, y, size, output hit, hitValid);
	modport build (input valid, index, chain, hit, hitValid);

endinterface

`default_nettype wire

// ==== hw/attrFetcher.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Attribute fetcher
// Banked attribute table, one bank per lane, written by the
// CPU one word at a time and read one group per cycle while
// the per-line scan runs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module attrFetcher import spriteAttrPkg::*; #(
	parameter int numLanes = 2,
	parameter int numSprites = 384
) (
	input logic clk24m,
	input logic reset,
	input logic tableWrite,
	input spriteIdxT tableAddr,
	input attrWordT tableData,
	input logic newLine,
	attrLaneIf.fetch lanes [numLanes],
	output logic scanBusy
);

	localparam int groups = numSprites / numLanes;
	localparam int rowW = $clog2(groups);

	logic scanning;
	logic laneValid;
	logic [rowW-1:0] grpAddr;
	logic [rowW-1:0] rdRow;
	logic [rowW-1:0] wrRow;

	// Low index bits pick the bank, the rest pick the row
	assign wrRow = rowW'(int'(tableAddr) / numLanes);
	assign scanBusy = scanning;

	// Group counter, restarted by every new line
	always_ff @(posedge clk24m) begin
		if (reset) begin
			scanning <= 1'b0;
			laneValid <= 1'b0;
			grpAddr <= '0;
		end else if (newLine) begin
			scanning <= 1'b1;
			laneValid <= 1'b0;
			grpAddr <= '0;
		end else begin
			laneValid <= scanning;
			if (scanning) begin
				if (grpAddr == rowW'(groups - 1))
					scanning <= 1'b0;
				grpAddr <= grpAddr + 1'b1;
			end
		end
	end

	// Row of the group now on the lanes
	always_ff @(posedge clk24m) begin
		if (scanning)
			rdRow <= grpAddr;
	end

	for (genvar b = 0; b < numLanes; b++) begin : bankGen
		attrWordT mem [groups];
		attrWordT rdWord;

		always_ff @(posedge clk24m) begin
			if (tableWrite && (int'(tableAddr) % numLanes) == b)
				mem[wrRow] <= tableData;
			if (scanning)
				rdWord <= mem[grpAddr];
		end

		assign lanes[b].valid = laneValid;
		assign lanes[b].index = spriteIdxT'(int'(rdRow) * numLanes + b);
		assign lanes[b].y = attrY(rdWord);
		assign lanes[b].size = attrSize(rdWord);
		assign lanes[b].chain = attrChain(rdWord);
	end

endmodule

`default_nettype wire

// ==== hw/spriteMatcher.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite matcher
// Decides whether the sprite on its lane covers the current
// raster line, registered once
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module spriteMatcher import spriteAttrPkg::*; (
	input logic clk24m,
	input logic reset,
	input rasterT raster,
	attrLaneIf.match lane
);

	rasterT lineOffset;
	rasterT span;

	// Distance below the sprite top, wraps at 512
	assign lineOffset = raster - lane.y;
	// Tiles are 16 lines tall
	assign span = {lane.size[4:0], 4'b0000};

	always_ff @(posedge clk24m) begin
		lane.hit <= lane.size[5] || (lineOffset < span);
	end

	always_ff @(posedge clk24m) begin
		if (reset)
			lane.hitValid <= 1'b0;
		else
			lane.hitValid <= lane.valid;
	end

endmodule

`default_nettype wire

// ==== hw/activeListBuilder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Active list builder
// Resolves sprite chaining across each group, packs the hits
// into the active list in ascending order and tracks count,
// overflow and the end of parsing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module activeListBuilder import spriteAttrPkg::*, parseCtrlPkg::*; #(
	parameter int numLanes = 2,
	parameter int numSprites = 384,
	parameter int maxActive = 96
) (
	input logic clk24m,
	input logic reset,
	input logic newLine,
	attrLaneIf.build lanes [numLanes],
	input listAddrT listRdAddr,
	output spriteIdxT listRdData,
	output listCountT activeCount,
	output logic listFull,
	output logic parseDone
);

	builderStateT state;
	logic inHit [numLanes];
	logic inHitV [numLanes];
	logic inChain [numLanes];
	spriteIdxT inIdx [numLanes];
	logic chainQ [numLanes];
	spriteIdxT idxQ [numLanes];
	logic validQ;
	logic groupValid;
	logic lastGroup;
	logic lastHit;
	logic nextHit;
	listCountT nextCount;
	logic wrEn [numLanes];
	listAddrT wrAddr [numLanes];
	spriteIdxT listMem [maxActive];

	for (genvar l = 0; l < numLanes; l++) begin : laneGen
		assign inHit[l] = lanes[l].hit;
		assign inHitV[l] = lanes[l].hitValid;
		assign inChain[l] = lanes[l].chain;
		assign inIdx[l] = lanes[l].index;
	end

	// Line up chain and index with the matcher output
	always_ff @(posedge clk24m) begin
		for (int l = 0; l < numLanes; l++) begin
			chainQ[l] <= inChain[l];
			idxQ[l] <= inIdx[l];
		end
	end

	// Dropped on new line so an old group in flight is ignored
	always_ff @(posedge clk24m) begin
		if (reset || newLine)
			validQ <= 1'b0;
		else
			validQ <= lanes[0].valid;
	end

	always_comb begin : groupCheck
		groupValid = validQ && state == scanning;
		for (int l = 0; l < numLanes; l++)
			groupValid = groupValid && inHitV[l];
	end

	assign lastGroup = groupValid && idxQ[numLanes-1] == spriteIdxT'(numSprites - 1);

	// Chain resolution and compaction in lane order
	always_comb begin : compact
		logic carry;
		logic hitNow;
		listCountT cnt;
		carry = lastHit;
		cnt = activeCount;
		for (int l = 0; l < numLanes; l++) begin
			// Sprite 0 never chains
			hitNow = (chainQ[l] && idxQ[l] != '0) ? carry : inHit[l];
			carry = hitNow;
			wrEn[l] = 1'b0;
			wrAddr[l] = '0;
			if (groupValid && hitNow && cnt < maxActive) begin
				wrEn[l] = 1'b1;
				wrAddr[l] = listAddrT'(cnt);
				cnt = cnt + 1'b1;
			end
		end
		nextHit = carry;
		nextCount = cnt;
	end

	always_ff @(posedge clk24m) begin
		for (int l = 0; l < numLanes; l++) begin
			if (wrEn[l])
				listMem[wrAddr[l]] <= idxQ[l];
		end
	end

	assign listRdData = (listRdAddr < maxActive) ? listMem[listRdAddr] : '0;

	always_ff @(posedge clk24m) begin
		if (reset) begin
			state <= idle;
			activeCount <= '0;
			listFull <= 1'b0;
			parseDone <= 1'b1;
			lastHit <= 1'b0;
		end else if (newLine) begin
			state <= scanning;
			activeCount <= '0;
			listFull <= 1'b0;
			parseDone <= 1'b0;
			lastHit <= 1'b0;
		end else begin
			case (state)
				scanning: begin
					if (groupValid) begin
						activeCount <= nextCount;
						lastHit <= nextHit;
						listFull <= nextCount == maxActive;
						if (lastGroup)
							state <= draining;
					end
				end
				draining: begin
					// Last group is in the list now
					parseDone <= 1'b1;
					state <= done;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/apbSlaveCtrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave
// Decodes table, active list and status accesses, stalls
// table and list accesses while a line is parsed and keeps
// a readback copy of the attribute table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module apbSlaveCtrl import spriteAttrPkg::*, parseCtrlPkg::*; #(
	parameter int numSprites = 384
) (
	input logic clk24m,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbAddrT paddr,
	input attrWordT pwdata,
	output logic [15:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic parseDone,
	input logic listFull,
	input listCountT activeCount,
	output logic tableWrite,
	output spriteIdxT tableAddr,
	output attrWordT tableData,
	output listAddrT listRdAddr,
	input spriteIdxT listRdData
);

	logic access;
	logic isTable;
	logic isList;
	logic isStatus;
	logic idxOk;
	logic waitFlag;
	apbAddrT tableOff;
	apbAddrT listOff;
	attrWordT shadow [numSprites];

	assign access = psel && penable;
	assign tableOff = paddr - tableBase;
	assign listOff = paddr - listBase;
	assign isTable = paddr < listBase;
	assign isList = paddr >= listBase && paddr < statusAddr;
	assign isStatus = paddr == statusAddr;
	assign tableAddr = tableOff[10:2];
	assign listRdAddr = listOff[8:2];
	assign idxOk = tableAddr < numSprites;

	// Armed in the setup phase and released once parsing ends
	always_ff @(posedge clk24m) begin
		if (reset)
			waitFlag <= 1'b0;
		else if (psel && !penable && (isTable || isList) && !parseDone)
			waitFlag <= 1'b1;
		else if (parseDone)
			waitFlag <= 1'b0;
	end

	assign pready = !waitFlag || parseDone;
	assign pslverr = access && pready && ((pwrite && !isTable) || (isTable && !idxOk));
	assign tableWrite = access && pready && pwrite && isTable && idxOk;
	assign tableData = pwdata;

	always_ff @(posedge clk24m) begin
		if (tableWrite)
			shadow[tableAddr] <= tableData;
	end

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			if (isStatus)
				prdata = {parseDone, listFull, 6'b000000, activeCount};
			else if (isTable && idxOk)
				prdata = shadow[tableAddr];
			else if (isList && listOff[9:2] < activeCount)
				prdata = {7'b0000000, listRdData};
		end
	end

endmodule

`default_nettype wire

// ==== hw/spriteParseTop.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite parser top
// Attribute fetcher, one matcher per lane, active list
// builder and the APB slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module spriteParseTop import spriteAttrPkg::*, parseCtrlPkg::*; #(
	parameter int numLanes = 2,
	parameter int numSprites = 384,
	parameter int maxActive = 96
) (
	input logic clk24m,
	input logic reset,
	input logic newLine,
	input rasterT raster,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbAddrT paddr,
	input attrWordT pwdata,
	output logic [15:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic tableWrite;
	spriteIdxT tableAddr;
	attrWordT tableData;
	logic scanBusy;
	listAddrT listRdAddr;
	spriteIdxT listRdData;
	listCountT activeCount;
	logic listFull;
	logic builderDone;
	logic tableIdle;

	attrLaneIf lanes [numLanes] ();

	// CPU waits while the fetcher or the builder is busy
	assign tableIdle = builderDone && !scanBusy;

	attrFetcher #(
		.numLanes(numLanes),
		.numSprites(numSprites)
	) fetcher (
		.clk24m(clk24m),
		.reset(reset),
		.tableWrite(tableWrite),
		.tableAddr(tableAddr),
		.tableData(tableData),
		.newLine(newLine),
		.lanes(lanes),
		.scanBusy(scanBusy)
	);

	for (genvar l = 0; l < numLanes; l++) begin : matchGen
		spriteMatcher matcher (
			.clk24m(clk24m),
			.reset(reset),
			.raster(raster),
			.lane(lanes[l])
		);
	end

	activeListBuilder #(
		.numLanes(numLanes),
		.numSprites(numSprites),
		.maxActive(maxActive)
	) builder (
		.clk24m(clk24m),
		.reset(reset),
		.newLine(newLine),
		.lanes(lanes),
		.listRdAddr(listRdAddr),
		.listRdData(listRdData),
		.activeCount(activeCount),
		.listFull(listFull),
		.parseDone(builderDone)
	);

	apbSlaveCtrl #(
		.numSprites(numSprites)
	) apb (
		.clk24m(clk24m),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.parseDone(tableIdle),
		.listFull(listFull),
		.activeCount(activeCount),
		.tableWrite(tableWrite),
		.tableAddr(tableAddr),
		.tableData(tableData),
		.listRdAddr(listRdAddr),
		.listRdData(listRdData)
	);

endmodule

`default_nettype wire

// ==== verif/clockGen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// Free running clock and a synchronous reset held for a
// fixed number of rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int period = 20,
	parameter int resetCycles = 16
) (
	output logic clk24m,
	output logic reset
);

	initial begin
		clk24m = 1'b0;
		forever #(period / 2) clk24m = ~clk24m;
	end

	// Released on a rising edge like any other input
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk24m);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/spriteParseTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite parser testbench
// Fills the attribute table over APB, parses raster lines and
// compares status and active list with a reference model;
// concurrent assertions check data, errors, wait states and
// parse timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module spriteParseTb import spriteAttrPkg::*, parseCtrlPkg::*; ();

	localparam int numLanes = 2;
	localparam int numSprites = 384;
	localparam int maxActive = 96;
	localparam int resetCycles = 16;
	localparam int groups = numSprites / numLanes;
	localparam int doneLatency = groups + 3;
	localparam int numTrips = 16;
	localparam int numLines = 5;
	// Three cycles per transfer and a scan plus polling slack per line
	localparam int apbXfers = 2 * numSprites + 2 * numTrips + 5 + (numLines + 2) * (maxActive + 3);
	localparam int totalCycles = resetCycles + 3 * apbXfers + (numLines + 2) * (doneLatency + 4);

	logic clk24m;
	logic reset;
	logic newLine;
	rasterT raster;
	logic psel;
	logic penable;
	logic pwrite;
	apbAddrT paddr;
	attrWordT pwdata;
	logic [15:0] prdata;
	logic pready;
	logic pslverr;

	logic parseDone;
	logic checkData;
	logic [15:0] expData;
	logic expErr;
	int lineCycles;
	attrWordT tableWords [numSprites];
	int modelList [numSprites];
	int modelCount;

	clockGen #(
		.period(20),
		.resetCycles(resetCycles)
	) clocks (
		.clk24m(clk24m),
		.reset(reset)
	);

	spriteParseTop #(
		.numLanes(numLanes),
		.numSprites(numSprites),
		.maxActive(maxActive)
	) dut (
		.clk24m(clk24m),
		.reset(reset),
		.newLine(newLine),
		.raster(raster),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	assign parseDone = dut.builderDone;

	// Cycles since the last new line saturate at the done latency
	always @(posedge clk24m) begin
		if (reset)
			lineCycles <= doneLatency;
		else if (newLine)
			lineCycles <= 0;
		else if (lineCycles < doneLatency)
			lineCycles <= lineCycles + 1;
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	readData: assert property (@(posedge clk24m) disable iff (reset)
		(psel && penable && pready && checkData) |-> (prdata == expData))
		else abortRun($sformatf("** Error at %0t: prdata expected %h, got %h",
			$time, $sampled(expData), $sampled(prdata)));

	errResp: assert property (@(posedge clk24m) disable iff (reset)
		(psel && penable && pready) |-> (pslverr == expErr))
		else abortRun($sformatf("** Error at %0t: pslverr expected %b, got %b",
			$time, $sampled(expErr), $sampled(pslverr)));

	// Table and list accesses stall while parsing but status reads never do
	apbReady: assert property (@(posedge clk24m) disable iff (reset)
		(psel && penable) |-> (pready == (lineCycles >= doneLatency || paddr == statusAddr)))
		else abortRun($sformatf("** Error at %0t: pready expected %b, got %b", $time,
			$sampled(lineCycles >= doneLatency || paddr == statusAddr), $sampled(pready)));

	doneTiming: assert property (@(posedge clk24m) disable iff (reset)
		parseDone == (lineCycles >= doneLatency))
		else abortRun($sformatf("** Error at %0t: parseDone expected %b, got %b", $time,
			$sampled(lineCycles >= doneLatency), $sampled(parseDone)));

	initial begin : watchdog
		repeat (4 * totalCycles) @(posedge clk24m);
		abortRun("Timeout: the run did not finish in the expected number of cycles");
	end

	task automatic apbAccess(input logic wr, input int addr, input attrWordT wdata,
		input logic chk, input logic [15:0] exp, input logic err, output logic [15:0] rdata);
		logic ready;
		@(posedge clk24m);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= apbAddrT'(addr);
		pwdata <= wdata;
		checkData <= chk && !wr;
		expData <= exp;
		expErr <= err;
		@(posedge clk24m);
		penable <= 1'b1;
		ready = 1'b0;
		// Sample mid cycle since the transfer ends on the next edge
		while (!ready) begin
			@(negedge clk24m);
			ready = pready;
			rdata = prdata;
			@(posedge clk24m);
		end
		psel <= 1'b0;
		penable <= 1'b0;
		checkData <= 1'b0;
	endtask

	task automatic writeWord(input int idx, input attrWordT word, input logic err);
		logic [15:0] unused;
		apbAccess(1'b1, int'(tableBase) + idx * 4, word, 1'b0, 16'h0000, err, unused);
	endtask

	task automatic readWord(input int idx, input attrWordT exp, input logic chk, input logic err);
		logic [15:0] unused;
		apbAccess(1'b0, int'(tableBase) + idx * 4, 16'h0000, chk, exp, err, unused);
	endtask

	task automatic readStatus(input logic [15:0] exp);
		logic [15:0] unused;
		apbAccess(1'b0, int'(statusAddr), 16'h0000, 1'b1, exp, 1'b0, unused);
	endtask

	task automatic readList(input int entry, input int exp);
		logic [15:0] unused;
		apbAccess(1'b0, int'(listBase) + entry * 4, 16'h0000, 1'b1, 16'(exp), 1'b0, unused);
	endtask

	task automatic waitParseDone();
		logic [15:0] status;
		status = 16'h0000;
		while (!status[15])
			apbAccess(1'b0, int'(statusAddr), 16'h0000, 1'b0, 16'h0000, 1'b0, status);
	endtask

	task automatic startLine(input rasterT line);
		@(posedge clk24m);
		newLine <= 1'b1;
		raster <= line;
		@(posedge clk24m);
		newLine <= 1'b0;
	endtask

	function automatic logic [15:0] statusWord(input logic done, input int count);
		return {done, count == maxActive, 6'b000000, 8'(count)};
	endfunction

	// Mostly small sprites, a few full height ones and some chains
	function automatic attrWordT randomWord();
		spriteYT y;
		logic chain;
		spriteSizeT size;
		int pick;
		y = spriteYT'($urandom);
		chain = ($urandom % 8) == 0;
		pick = $urandom % 24;
		size = (pick == 0) ? 6'(32 + $urandom % 32) : 6'($urandom % 4);
		return {y, chain, size};
	endfunction

	function automatic void buildModel(input rasterT line);
		int offset;
		int ySpr;
		int height;
		logic own;
		logic hit;
		logic prevHit;
		modelCount = 0;
		prevHit = 1'b0;
		for (int i = 0; i < numSprites; i++) begin
			ySpr = int'(tableWords[i][15:7]);
			height = int'(tableWords[i][5:0]);
			offset = (int'(line) - ySpr + 512) % 512;
			own = (height >= 32) || (offset < height * 16);
			hit = (tableWords[i][6] && i != 0) ? prevHit : own;
			prevHit = hit;
			if (hit && modelCount < maxActive) begin
				modelList[modelCount] = i;
				modelCount++;
			end
		end
	endfunction

	task automatic checkList(input rasterT line);
		buildModel(line);
		readStatus(statusWord(1'b1, modelCount));
		for (int i = 0; i < modelCount; i++)
			readList(i, modelList[i]);
		// First entry past the count reads as zero
		readList(modelCount, 0);
	endtask

	initial begin : stimulus
		int idx;
		attrWordT word;
		rasterT line;
		newLine = 1'b0;
		raster = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		checkData = 1'b0;
		expData = '0;
		expErr = 1'b0;
		void'($urandom(32'hbea7));
		wait (!reset);

		readStatus(statusWord(1'b1, 0));

		for (int i = 0; i < numSprites; i++) begin
			tableWords[i] = randomWord();
			writeWord(i, tableWords[i], 1'b0);
		end

		// Table round trip and error responses
		for (int t = 0; t < numTrips; t++) begin
			idx = $urandom % numSprites;
			word = attrWordT'($urandom);
			tableWords[idx] = word;
			writeWord(idx, word, 1'b0);
			readWord(idx, word, 1'b1, 1'b0);
		end
		idx = numSprites + $urandom % (512 - numSprites);
		writeWord(idx, 16'h1234, 1'b1);
		readWord(idx, 16'h0000, 1'b0, 1'b1);
		writeWord(512, 16'h5678, 1'b1);
		writeWord(768, 16'h9abc, 1'b1);

		for (int n = 0; n < numLines; n++) begin
			line = rasterT'($urandom);
			startLine(line);
			waitParseDone();
			checkList(line);
		end

		// Wait states while parsing
		line = rasterT'($urandom);
		startLine(line);
		readStatus(statusWord(1'b0, 0));
		idx = $urandom % numSprites;
		readWord(idx, tableWords[idx], 1'b1, 1'b0);
		checkList(line);

		// Every sprite full height fills the list
		for (int i = 0; i < numSprites; i++) begin
			tableWords[i] = {spriteYT'($urandom), 1'b0, 6'd32};
			writeWord(i, tableWords[i], 1'b0);
		end
		startLine(rasterT'($urandom));
		waitParseDone();
		readStatus(statusWord(1'b1, maxActive));
		for (int i = 0; i < maxActive; i++)
			readList(i, i);
		readList(maxActive, 0);

		@(posedge clk24m);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/spriteAttrPkg.sv
hw/parseCtrlPkg.sv
hw/attrLaneIf.sv
hw/attrFetcher.sv
hw/spriteMatcher.sv
hw/activeListBuilder.sv
hw/apbSlaveCtrl.sv
hw/spriteParseTop.sv
verif/clockGen.sv
verif/spriteParseTb.sv

// ==== Bender.yml ====
package:
  name: sprite_parse

sources:
  - hw/spriteAttrPkg.sv
  - hw/parseCtrlPkg.sv
  - hw/attrLaneIf.sv
  - hw/attrFetcher.sv
  - hw/spriteMatcher.sv
  - hw/activeListBuilder.sv
  - hw/apbSlaveCtrl.sv
  - hw/spriteParseTop.sv
  - target: test
    files:
      - verif/clockGen.sv
      - verif/spriteParseTb.sv
